// ==== source/pdp8Pkg.sv ====
package pdp8Pkg;

  // One 12-bit data or address word
  typedef logic [11:0] pdpWord;

  // Major opcodes in IR bits 11..9
  typedef enum logic [2:0] {
    opAnd, opTad, opIsz, opDca, opJms, opJmp, opIot, opOpr
  } opcodeE;

  // Major states of the instruction sequencer
  typedef enum logic [2:0] {
    idle,
    fetchRead, fetchDecode,
    deferRead, deferLatch,
    execRead, execOperate,
    writeBack
  } majorStateE;

  // Instruction field positions
  localparam int opcodeMsb   = 11;
  localparam int indirectBit = 8;
  localparam int pageBit     = 7;
  localparam int offsetWidth = 7;
  localparam int pageWidth   = 5;

  // Operate group select, bit 0 splits group 2 from group 3
  localparam int groupBit  = 8;
  localparam int group3Bit = 0;

  // Group 1 microcode bits
  localparam int claBit   = 7;
  localparam int cllBit   = 6;
  localparam int cmaBit   = 5;
  localparam int cmlBit   = 4;
  localparam int rarBit   = 3;
  localparam int ralBit   = 2;
  localparam int twiceBit = 1;
  localparam int iacBit   = 0;

  // Group 2 microcode bits, CLA shares claBit
  localparam int smaBit    = 6;
  localparam int szaBit    = 5;
  localparam int snlBit    = 4;
  localparam int invertBit = 3;
  localparam int hltBit    = 1;

endpackage

// ==== source/coreMemory.sv ====
`timescale 1ns/1ps

module coreMemory import pdp8Pkg::*; #(
  parameter int memWords = 4096
) (
  input  bit     SYSCLK,
  input  bit     we,
  input  pdpWord addr,
  input  pdpWord writeData,
  input  pdpWord readAddr,
  output pdpWord readData
);

  localparam int addrBits = (memWords > 1) ? $clog2(memWords) : 1;

  // Word array, contents undefined until deposited
  pdpWord mem [memWords];

  logic [addrBits-1:0] writeIndex;
  logic [addrBits-1:0] readIndex;

  // Addresses past the top of memory fold back onto it
  assign writeIndex = addrBits'(addr % memWords);
  assign readIndex  = addrBits'(readAddr % memWords);

  always_ff @(posedge SYSCLK) begin
    if (we) begin
      mem[writeIndex] <= writeData;
    end
    // Registered read, data valid the cycle after the address
    // A write to the same word returns the old contents
    readData <= mem[readIndex];
  end

endmodule

// ==== source/memRefUnit.sv ====
`timescale 1ns/1ps

module memRefUnit import pdp8Pkg::*; (
  input  opcodeE opcode,
  input  pdpWord ac,
  input  pdpWord operand,
  output pdpWord result,
  output bit     carry,
  output bit     zero
);

  // 13-bit sums keep the carry out of bit 11
  logic [12:0] addSum;
  logic [12:0] incSum;

  // TAD adds the memory word to AC
  assign addSum = {1'b0, ac} + {1'b0, operand};

  // ISZ increments the memory word itself
  assign incSum = {1'b0, operand} + 13'd1;

  always_comb begin
    result = operand;
    carry  = 1'b0;
    zero   = 1'b0;
    case (opcode)
      opAnd: begin
        // Mask AC with the operand
        result = ac & operand;
      end
      opTad: begin
        // Carry toggles the link in the sequencer
        result = addSum[11:0];
        carry  = addSum[12];
      end
      opIsz: begin
        // Wrap from 7777 to 0000 requests the skip
        result = incSum[11:0];
        zero   = incSum[12];
      end
      default: begin
        // DCA, JMS, JMP and the rest take no arithmetic
        result = operand;
      end
    endcase
  end

endmodule

// ==== source/operateUnit.sv ====
`timescale 1ns/1ps

module operateUnit import pdp8Pkg::*; (
  input  pdpWord ir,
  input  pdpWord ac,
  input  bit     link,
  output pdpWord newAc,
  output bit     newLink,
  output bit     skip,
  output bit     haltRequest
);

  logic        group1;
  logic        group2;
  // Link and AC handled as one 13-bit value, link on top
  logic [12:0] g1Clear;
  logic [12:0] g1Comp;
  logic [12:0] g1Inc;
  logic [12:0] g1Rot;
  logic        acZero;
  logic        anyCondition;

  // Bit 8 clear is group 1, bit 8 set with bit 0 clear is group 2
  assign group1 = ~ir[groupBit];
  assign group2 = ir[groupBit] & ~ir[group3Bit];

  // Step 1, CLA and CLL
  assign g1Clear = {ir[cllBit] ? 1'b0 : link, ir[claBit] ? 12'o0000 : ac};

  // Step 2, CMA and CML
  assign g1Comp = g1Clear ^ {ir[cmlBit], {12{ir[cmaBit]}}};

  // Step 3, IAC carries out of AC into the link
  assign g1Inc = g1Comp + 13'(ir[iacBit]);

  // Step 4, rotates by one or two, or BSW
  always_comb begin
    case ({ir[rarBit], ir[ralBit]})
      2'b10: begin
        // RAR and RTR
        g1Rot = ir[twiceBit] ? {g1Inc[1:0], g1Inc[12:2]} : {g1Inc[0], g1Inc[12:1]};
      end
      2'b01: begin
        // RAL and RTL
        g1Rot = ir[twiceBit] ? {g1Inc[10:0], g1Inc[12:11]} : {g1Inc[11:0], g1Inc[12]};
      end
      2'b00: begin
        // BSW swaps the six-bit halves, link untouched
        g1Rot = ir[twiceBit] ? {g1Inc[12], g1Inc[5:0], g1Inc[11:6]} : g1Inc;
      end
      default: begin
        // Both rotate bits together do nothing here
        g1Rot = g1Inc;
      end
    endcase
  end

  // Skip conditions sampled before CLA
  assign acZero = (ac == 12'o0000);
  assign anyCondition = (ir[smaBit] & ac[11]) |
                        (ir[szaBit] & acZero) |
                        (ir[snlBit] & link);

  // Inverted sense gives SPA, SNA, SZL ANDed, and SKP with none set
  assign skip = group2 & (ir[invertBit] ? ~anyCondition : anyCondition);

  assign haltRequest = group2 & ir[hltBit];

  always_comb begin
    // Group 3 words fall through unchanged
    newAc   = ac;
    newLink = link;
    if (group1) begin
      newAc   = g1Rot[11:0];
      newLink = g1Rot[12];
    end else if (group2) begin
      // CLA after the test, OSR reads as zero
      newAc = ir[claBit] ? 12'o0000 : ac;
    end
  end

endmodule

// ==== source/majorStateSequencer.sv ====
`timescale 1ns/1ps

module majorStateSequencer import pdp8Pkg::*; #(
  parameter pdpWord resetVector = 12'o0200
) (
  input  bit     SYSCLK,
  input  bit     reset,
  input  bit     run,
  input  bit     halt,
  // Core memory
  input  pdpWord memReadData,
  output pdpWord memAddr,
  output bit     memWrite,
  output pdpWord memWriteData,
  // Memory reference arithmetic
  output opcodeE mrOpcode,
  output pdpWord mrOperand,
  input  pdpWord mrResult,
  input  bit     mrCarry,
  input  bit     mrZero,
  // Operate microcode
  input  pdpWord opNewAc,
  input  bit     opNewLink,
  input  bit     opSkip,
  input  bit     opHalt,
  // Processor registers
  output pdpWord ir,
  output pdpWord pc,
  output pdpWord ac,
  output bit     link,
  output bit     running,
  output bit     instrDone
);

  majorStateE state;
  majorStateE afterRetire;
  pdpWord     ea;
  pdpWord     dataLatch;
  pdpWord     pcInc;
  opcodeE     fetchedOp;
  opcodeE     irOp;
  logic       fetchedIndirect;
  logic       needsWriteBack;
  logic       retire;
  logic       stopNow;

  // Page zero or page of the instruction itself
  function automatic pdpWord directAddress(pdpWord word, pdpWord instrAddr);
    logic [pageWidth-1:0] page;
    page = word[pageBit] ? instrAddr[opcodeMsb -: pageWidth] : '0;
    return {page, word[offsetWidth-1:0]};
  endfunction

  function automatic logic isMemRef(opcodeE op);
    return op inside {opAnd, opTad, opIsz, opDca, opJms, opJmp};
  endfunction

  // Opcodes that need the operand word read
  function automatic logic readsOperand(opcodeE op);
    return op inside {opAnd, opTad, opIsz};
  endfunction

  // Decode straight off the read data during fetchDecode
  assign fetchedOp       = opcodeE'(memReadData[opcodeMsb -: 3]);
  assign fetchedIndirect = memReadData[indirectBit] & isMemRef(fetchedOp);
  assign irOp            = opcodeE'(ir[opcodeMsb -: 3]);

  assign pcInc = pc + 12'd1;

  // ISZ, DCA and JMS end with a memory write
  assign needsWriteBack = irOp inside {opIsz, opDca, opJms};
  assign retire = ((state == execOperate) && !needsWriteBack) || (state == writeBack);

  // HLT, or the panel halt level, stops at the end of this instruction
  assign stopNow     = halt || ((irOp == opOpr) && opHalt);
  assign afterRetire = stopNow ? idle : fetchRead;

  // Arithmetic unit sees the operand as it leaves memory
  assign mrOpcode  = irOp;
  assign mrOperand = memReadData;

  // Address mux, PC unless the effective address is wanted
  always_comb begin
    case (state)
      deferRead, execRead, writeBack: memAddr = ea;
      default: memAddr = pc;
    endcase
  end

  assign memWrite     = (state == writeBack);
  assign memWriteData = dataLatch;

  // IR, effective address and write data latches
  always_ff @(posedge SYSCLK) begin
    if (state == fetchDecode) begin
      ir <= memReadData;
      ea <= directAddress(memReadData, pc);
    end else if (state == deferLatch) begin
      // One level of indirection
      ea <= memReadData;
    end
    if (state == execOperate) begin
      // ISZ result, DCA accumulator, or JMS return address
      case (irOp)
        opIsz: dataLatch <= mrResult;
        opDca: dataLatch <= ac;
        default: dataLatch <= pc;
      endcase
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (reset) begin
      state     <= idle;
      pc        <= resetVector;
      ac        <= 12'o0000;
      link      <= 1'b0;
      running   <= 1'b0;
      instrDone <= 1'b0;
    end else begin
      instrDone <= retire;
      if (retire && stopNow) begin
        running <= 1'b0;
      end
      case (state)
        idle: begin
          if (run) begin
            running <= 1'b1;
            state   <= fetchRead;
          end
        end
        fetchRead: begin
          state <= fetchDecode;
        end
        fetchDecode: begin
          pc <= pcInc;
          if (fetchedIndirect) begin
            state <= deferRead;
          end else if (readsOperand(fetchedOp)) begin
            state <= execRead;
          end else begin
            state <= execOperate;
          end
        end
        deferRead: begin
          state <= deferLatch;
        end
        deferLatch: begin
          state <= readsOperand(irOp) ? execRead : execOperate;
        end
        execRead: begin
          state <= execOperate;
        end
        execOperate: begin
          case (irOp)
            opAnd: ac <= mrResult;
            opTad: begin
              ac   <= mrResult;
              link <= link ^ mrCarry;
            end
            opIsz: begin
              if (mrZero) begin
                pc <= pcInc;
              end
            end
            opJmp: pc <= ea;
            opOpr: begin
              ac   <= opNewAc;
              link <= opNewLink;
              if (opSkip) begin
                pc <= pcInc;
              end
            end
            // IOT is a no-op, DCA and JMS finish in writeBack
            default: ;
          endcase
          state <= needsWriteBack ? writeBack : afterRetire;
        end
        writeBack: begin
          if (irOp == opDca) begin
            ac <= 12'o0000;
          end
          // Subroutine body starts after the stored return address
          if (irOp == opJms) begin
            pc <= ea + 12'd1;
          end
          state <= afterRetire;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

// ==== source/pdp8Cpu.sv ====
`timescale 1ns/1ps

module pdp8Cpu import pdp8Pkg::*; #(
  parameter int     memWords    = 4096,
  parameter pdpWord resetVector = 12'o0200
) (
  input  bit     SYSCLK,
  input  bit     reset,
  input  bit     run,
  input  bit     halt,
  input  bit     deposit,
  input  pdpWord depositAddr,
  input  pdpWord depositData,
  output bit     running,
  output bit     instrDone,
  output pdpWord pc,
  output pdpWord ac,
  output bit     link
);

  pdpWord seqMemAddr;
  pdpWord seqMemWriteData;
  pdpWord memReadData;
  pdpWord memWriteAddr;
  pdpWord memWriteData;
  pdpWord mrOperand;
  pdpWord mrResult;
  pdpWord opNewAc;
  pdpWord ir;
  opcodeE mrOpcode;
  logic   seqMemWrite;
  logic   memWe;
  logic   mrCarry;
  logic   mrZero;
  logic   opNewLink;
  logic   opSkip;
  logic   opHalt;

  // Deposit port owns the write side while stopped
  assign memWe        = running ? seqMemWrite : deposit;
  assign memWriteAddr = running ? seqMemAddr : depositAddr;
  assign memWriteData = running ? seqMemWriteData : depositData;

  coreMemory #(
    .memWords(memWords)
  ) coreMemory_i (
    .SYSCLK(SYSCLK), .we(memWe), .addr(memWriteAddr), .writeData(memWriteData),
    .readAddr(seqMemAddr), .readData(memReadData)
  );

  memRefUnit memRefUnit_i (
    .opcode(mrOpcode), .ac(ac), .operand(mrOperand),
    .result(mrResult), .carry(mrCarry), .zero(mrZero)
  );

  operateUnit operateUnit_i (
    .ir(ir), .ac(ac), .link(link),
    .newAc(opNewAc), .newLink(opNewLink), .skip(opSkip), .haltRequest(opHalt)
  );

  majorStateSequencer #(
    .resetVector(resetVector)
  ) majorStateSequencer_i (
    .SYSCLK(SYSCLK), .reset(reset), .run(run), .halt(halt),
    .memReadData(memReadData), .memAddr(seqMemAddr),
    .memWrite(seqMemWrite), .memWriteData(seqMemWriteData),
    .mrOpcode(mrOpcode), .mrOperand(mrOperand),
    .mrResult(mrResult), .mrCarry(mrCarry), .mrZero(mrZero),
    .opNewAc(opNewAc), .opNewLink(opNewLink), .opSkip(opSkip), .opHalt(opHalt),
    .ir(ir), .pc(pc), .ac(ac), .link(link),
    .running(running), .instrDone(instrDone)
  );

endmodule

// ==== include/pdp8RefModel.svh ====
`ifndef PDP8_REF_MODEL_SVH
`define PDP8_REF_MODEL_SVH

// Steps mPc, mAc, mLink and the mirror memory through one instruction
// Returns 1 when the instruction stops the processor
function automatic bit stepInstruction();
  pdpWord      instr;
  pdpWord      addr;
  logic [12:0] lac;
  logic [12:0] sum;
  bit          cond;
  bit          stop;
  instr = mirror[mPc];
  stop  = 1'b0;
  // Offset within page zero or within the page holding the instruction
  addr = (instr & 12'o0177) | (instr[pageBit] ? (mPc & 12'o7600) : 12'o0000);
  mPc  = mPc + 12'd1;
  // Memory reference opcodes 0 to 5 may go through one pointer
  if (instr[opcodeMsb -: 3] <= 3'd5 && instr[indirectBit]) begin
    addr = mirror[addr];
  end
  case (opcodeE'(instr[opcodeMsb -: 3]))
    opAnd: mAc = mAc & mirror[addr];
    opTad: begin
      sum = mAc + mirror[addr];
      mAc = sum[11:0];
      // Carry out flips the link
      if (sum[12]) begin
        mLink = ~mLink;
      end
    end
    opIsz: begin
      mirror[addr] = mirror[addr] + 12'd1;
      if (mirror[addr] == 12'o0000) begin
        mPc = mPc + 12'd1;
      end
    end
    opDca: begin
      mirror[addr] = mAc;
      mAc = 12'o0000;
    end
    opJms: begin
      // Return address goes in the first word of the subroutine
      mirror[addr] = mPc;
      mPc = addr + 12'd1;
    end
    opJmp: mPc = addr;
    opOpr: begin
      if (!instr[groupBit]) begin
        lac = {mLink, mAc};
        // Clears, complements, increment, then rotate or swap
        if (instr[claBit]) lac = lac & 13'o10000;
        if (instr[cllBit]) lac = lac & 13'o07777;
        if (instr[cmaBit]) lac = lac ^ 13'o07777;
        if (instr[cmlBit]) lac = lac ^ 13'o10000;
        if (instr[iacBit]) lac = lac + 13'd1;
        if (instr[rarBit] && !instr[ralBit]) begin
          repeat (instr[twiceBit] ? 2 : 1) lac = {lac[0], lac[12:1]};
        end else if (instr[ralBit] && !instr[rarBit]) begin
          repeat (instr[twiceBit] ? 2 : 1) lac = {lac[11:0], lac[12]};
        end else if (!instr[rarBit] && !instr[ralBit] && instr[twiceBit]) begin
          lac = {lac[12], lac[5:0], lac[11:6]};
        end
        mLink = lac[12];
        mAc   = lac[11:0];
      end else if (!instr[group3Bit]) begin
        // Test uses AC and link before CLA
        cond = (instr[smaBit] && mAc[11]) || (instr[szaBit] && mAc == 12'o0000) ||
               (instr[snlBit] && mLink);
        if (instr[invertBit]) cond = !cond;
        if (cond) mPc = mPc + 12'd1;
        if (instr[claBit]) mAc = 12'o0000;
        stop = instr[hltBit];
      end
    end
    default: ;
  endcase
  return stop;
endfunction

`endif

// ==== verif/pdp8CpuTb.sv ====
`timescale 1ns/1ps

module pdp8CpuTb import pdp8Pkg::*; ();

  // Instructions in the two operate runs, arithmetic, control flow and the longest ISZ loop
  localparam int expectedInstr = 2 * 122 + 14 + 17 + 43;
  // Deposit cycles of each test plus run pulses with quiet time and reset
  localparam int loadCycles    = 2 * 153 + 19 + 24 + 8 + 5 * 22 + 16;
  // Seven cycles covers the slowest instruction
  localparam int cycleLimit    = 7 * expectedInstr + loadCycles + 200;

  bit     SYSCLK;
  bit     reset;
  bit     run;
  bit     halt;
  bit     deposit;
  pdpWord depositAddr;
  pdpWord depositData;
  bit     running;
  bit     instrDone;
  pdpWord pc;
  pdpWord ac;
  bit     link;

  // Mirror memory and model registers
  pdpWord mirror [4096];
  pdpWord mPc;
  pdpWord mAc;
  bit     mLink;
  bit     modelStopped;
  int     retired;
  int     cycles;
  int     seed;
  int     pulses;
  int     loopCount;
  pdpWord loadAddr;
  pdpWord codeWords [$];

  `include "pdp8RefModel.svh"

  pdp8Cpu #(
    .memWords(4096),
    .resetVector(12'o0200)
  ) pdp8Cpu_i (
    .SYSCLK(SYSCLK), .reset(reset), .run(run), .halt(halt),
    .deposit(deposit), .depositAddr(depositAddr), .depositData(depositData),
    .running(running), .instrDone(instrDone), .pc(pc), .ac(ac), .link(link)
  );

  always #2 SYSCLK = ~SYSCLK;

  task automatic abortRun(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input pdpWord got, input pdpWord expected);
    if (got !== expected) begin
      abortRun($sformatf("FAIL at %0t: %s is %04o, expected %04o", $time, name, got, expected));
    end
  endtask

  task automatic checkBit(input string name, input bit got, input bit expected);
    if (got !== expected) begin
      abortRun($sformatf("FAIL at %0t: %s is %0b, expected %0b", $time, name, got, expected));
    end
  endtask

  // Deposit stays high so back-to-back words take one cycle each
  task automatic depositWord(input pdpWord addr, input pdpWord data);
    @(negedge SYSCLK);
    deposit     = 1'b1;
    depositAddr = addr;
    depositData = data;
    mirror[addr] = data;
  endtask

  task automatic appendWord(input pdpWord data);
    depositWord(loadAddr, data);
    loadAddr = loadAddr + 12'd1;
  endtask

  task automatic depositBlock(input pdpWord addr);
    foreach (codeWords[k]) begin
      depositWord(addr + pdpWord'(k), codeWords[k]);
    end
  endtask

  // Enter through JMP I 0007 placed after the last halt, then wait for HLT
  task automatic runProgram(input pdpWord start, output int count);
    int startCount;
    depositWord(12'o0007, start);
    depositWord(mPc, 12'o5407);
    startCount = retired;
    modelStopped = 1'b0;
    @(negedge SYSCLK);
    deposit = 1'b0;
    run     = 1'b1;
    @(negedge SYSCLK);
    run = 1'b0;
    wait (modelStopped);
    // No instruction may retire during the quiet time
    repeat (20) @(negedge SYSCLK);
    count = retired - startCount;
  endtask

  function automatic pdpWord randomGroup1();
    pdpWord word;
    word = 12'o7000 | (pdpWord'($random(seed)) & 12'o0377);
    // RAR and RAL together left out
    if (word[rarBit] && word[ralBit]) begin
      word[ralBit] = 1'b0;
    end
    return word;
  endfunction

  // Each step is CLA CLL with random CML and TAD of a random constant
  // followed by two group 1 words, or by a skip word and IAC
  task automatic operateTest(input bit skipMode, input pdpWord start);
    int     i;
    pdpWord word;
    for (i = 0; i < 30; i++) begin
      word = pdpWord'($random(seed));
      // Zero AC now and then for SZA
      if (skipMode && word[1:0] == 2'b00) word = 12'o0000;
      depositWord(12'o0020 + pdpWord'(i), word);
    end
    loadAddr = start;
    for (i = 0; i < 30; i++) begin
      appendWord(12'o7300 | (pdpWord'($random(seed)) & 12'o0020));
      appendWord(12'o1020 + pdpWord'(i));
      if (skipMode) begin
        appendWord(12'o7400 | (pdpWord'($random(seed)) & 12'o0374));
        appendWord(12'o7001);
      end else begin
        appendWord(randomGroup1());
        appendWord(randomGroup1());
      end
    end
    appendWord(12'o7402);
    runProgram(start, pulses);
  endtask

  // TAD overflow, AND mask, DCA with read back, TAD through a pointer
  task automatic arithmeticTest();
    codeWords = '{12'o7300, 12'o1300, 12'o1301, 12'o1301, 12'o1301, 12'o0302, 12'o3303,
                  12'o1303, 12'o1300, 12'o3304, 12'o1304, 12'o1705, 12'o7402};
    depositBlock(12'o1000);
    depositWord(12'o1100, pdpWord'($random(seed)) | 12'o4000);
    depositWord(12'o1101, pdpWord'($random(seed)) | 12'o4000);
    depositWord(12'o1102, pdpWord'($random(seed)));
    depositWord(12'o1105, 12'o1100);
    runProgram(12'o1000, pulses);
  endtask

  // JMS to page zero and current page, JMP over a word, chained indirect JMPs
  task automatic controlFlowTest();
    codeWords = '{12'o7300, 12'o4100, 12'o7300, 12'o1100, 12'o4300, 12'o7300, 12'o1300,
                  12'o5211, 12'o7001, 12'o5104};
    depositBlock(12'o2000);
    codeWords = '{12'o0000, 12'o7001, 12'o5500, 12'o0000, 12'o5505, 12'o2112};
    depositBlock(12'o0100);
    codeWords = '{12'o0000, 12'o7001, 12'o5700};
    depositBlock(12'o2100);
    depositWord(12'o2110, 12'o2120);
    depositWord(12'o2112, 12'o5710);
    depositWord(12'o2120, 12'o7402);
    runProgram(12'o2000, pulses);
  endtask

  // ISZ counts from minus N up to zero, then TAD reads the counter back
  task automatic loopTest();
    loopCount = 5 + ($random(seed) & 15);
    codeWords = '{12'o7300, 12'o2300, 12'o5201, 12'o1300, 12'o7402};
    depositBlock(12'o2200);
    depositWord(12'o2300, 12'o0000 - pdpWord'(loopCount));
    runProgram(12'o2200, pulses);
    // Entry JMP, CLA, N ISZ, N-1 JMP, TAD, HLT
    if (pulses != 2 * loopCount + 3) begin
      abortRun($sformatf("ISZ loop retired %0d instructions instead of %0d",
                         pulses, 2 * loopCount + 3));
    end
  endtask

  // Outputs have settled since the rising edge when the model steps
  always @(negedge SYSCLK) begin
    if (!reset && instrDone) begin
      if (modelStopped) begin
        abortRun("An instruction retired while the processor should be halted");
      end else begin
        modelStopped = stepInstruction();
        retired++;
        checkWord("pc", pc, mPc);
        checkWord("ac", ac, mAc);
        checkBit("link", link, mLink);
        checkBit("running", running, ~modelStopped);
      end
    end
  end

  // Watchdog
  always @(posedge SYSCLK) begin
    cycles++;
    if (cycles > cycleLimit) begin
      abortRun($sformatf("Timeout after %0d cycles, the processor never halted", cycles));
    end
  end

  initial begin
    seed         = 2;
    reset        = 1'b1;
    run          = 1'b0;
    halt         = 1'b0;
    deposit      = 1'b0;
    depositAddr  = 12'o0000;
    depositData  = 12'o0000;
    mPc          = 12'o0200;
    mAc          = 12'o0000;
    mLink        = 1'b0;
    modelStopped = 1'b1;
    retired      = 0;
    cycles       = 0;
    repeat (16) @(negedge SYSCLK);
    reset = 1'b0;
    checkWord("pc", pc, 12'o0200);
    checkWord("ac", ac, 12'o0000);
    checkBit("link", link, 1'b0);
    checkBit("running", running, 1'b0);
    operateTest(1'b0, 12'o0400);
    operateTest(1'b1, 12'o0600);
    arithmeticTest();
    controlFlowTest();
    loopTest();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
source/pdp8Pkg.sv
source/coreMemory.sv
source/memRefUnit.sv
source/operateUnit.sv
source/majorStateSequencer.sv
source/pdp8Cpu.sv
verif/pdp8CpuTb.sv

// ==== Bender.yml ====
package:
  name: pdp8cpu

sources:
  - source/pdp8Pkg.sv
  - source/coreMemory.sv
  - source/memRefUnit.sv
  - source/operateUnit.sv
  - source/majorStateSequencer.sv
  - source/pdp8Cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/pdp8CpuTb.sv
